// File: filelist.f
+incdir+verilog
verilog/mmioBusPkg.sv
verilog/periphPkg.sv
verilog/busFrontEnd.sv
verilog/machineTimer.sv
verilog/spiMaster.sv
verilog/sysCon.sv
verilog/mmioSubsystem.sv
dv/mmioSubsystemTb.sv

// File: Bender.yml
package:
  name: mmio_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mmioBusPkg.sv
      - verilog/periphPkg.sv
      - verilog/busFrontEnd.sv
      - verilog/machineTimer.sv
      - verilog/spiMaster.sv
      - verilog/sysCon.sv
      - verilog/mmioSubsystem.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/mmioSubsystemTb.sv

// File: dv/mmioSubsystemTb.sv
`default_nettype none

`include "mmio_params.svh"

module mmioSubsystemTb;

    localparam int maxRows = 48;
    localparam int driveDelay = 5;
    localparam bit opRead = 1'b0;
    localparam bit opWrite = 1'b1;
    localparam logic [31:0] timerByte = `MMIO_TIMER_BASE;
    localparam logic [31:0] spiByte = `MMIO_SPI_BASE;
    localparam logic [31:0] sysByte = `MMIO_SYSCON_BASE;
    localparam logic [31:0] holeByte = `MMIO_TIMER_BASE + 32'h40; // Outside every window.

    logic clk;
    logic rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [3:0] wbSel;
    logic [`MMIO_ADR_W-1:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic wbAck;
    logic timerIrq;
    logic spiCs;
    logic spiSck;
    logic spiMosi;
    logic spiMiso;
    logic reboot;
    logic powerOff;

    bit tblOp [maxRows];
    logic [31:0] tblAdr [maxRows];
    logic [3:0] tblSel [maxRows];
    logic [31:0] tblData [maxRows];
    logic [31:0] tblExpRd [maxRows];
    int tblExpIrq [maxRows];     // -1 skips the check.
    int tblExpEdges [maxRows];   // -1 skips the check.
    int tblExpReboot [maxRows];
    int tblExpPowerOff [maxRows];
    logic [31:0] spiData [5];

    integer seed = 32'h4f3d_2b23;
    int rowCount = 0;
    int expWindows = 0;
    int cycleLimit = 0;
    int cycles = 0;
    int errors = 0;
    int edgeCnt = 0;
    int windowEdges = 0;
    int windowCnt = 0;
    int rebootCnt = 0;
    int powerOffCnt = 0;

    mmioSubsystem mmioSubsystem_i (
        .clk(clk),
        .rst(rst),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbSel(wbSel),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .spiMiso(spiMiso),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .timerIrq(timerIrq),
        .spiCs(spiCs),
        .spiSck(spiSck),
        .spiMosi(spiMosi),
        .reboot(reboot),
        .powerOff(powerOff)
    );

    assign spiMiso = rst ? 1'b0 : spiMosi; // Loopback.

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            errors = errors + 1;
            $display("timeout: acknowledge never arrived");
            $display("Errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // SPI clock edges inside each chip-select window.
    always @(posedge spiSck) begin
        if (!rst && !spiCs) edgeCnt = edgeCnt + 1;
    end

    always @(negedge spiCs) begin
        if (!rst) edgeCnt = 0;
    end

    always @(posedge spiCs) begin
        if (!rst) begin
            windowEdges = edgeCnt;
            windowCnt = windowCnt + 1;
        end
    end

    always @(negedge clk) begin
        if (!rst && reboot) rebootCnt = rebootCnt + 1;
        if (!rst && powerOff) powerOffCnt = powerOffCnt + 1;
    end

    task automatic addRow(input bit op, input logic [31:0] adr, input logic [3:0] sel,
                          input logic [31:0] data, input logic [31:0] expRd, input int expIrq,
                          input int expEdges, input int expReboot, input int expPowerOff);
        tblOp[rowCount] = op;
        tblAdr[rowCount] = adr;
        tblSel[rowCount] = sel;
        tblData[rowCount] = data;
        tblExpRd[rowCount] = expRd;
        tblExpIrq[rowCount] = expIrq;
        tblExpEdges[rowCount] = expEdges;
        tblExpReboot[rowCount] = expReboot;
        tblExpPowerOff[rowCount] = expPowerOff;
        if (op == opWrite && adr == spiByte) expWindows = expWindows + 1;
        rowCount = rowCount + 1;
    endtask

    task automatic buildTable();
        for (int i = 0; i < 5; i++) begin
            spiData[i] = $random(seed);
        end
        // Timer registers, merged per byte lane.
        addRow(opWrite, timerByte, 4'hF, 32'h1234_5678, 0, 1, -1, 0, 0);
        addRow(opRead, timerByte, 4'hF, 0, 32'h1234_5678, 1, -1, 0, 0);
        addRow(opWrite, timerByte, 4'h5, 32'hAABB_CCDD, 0, 1, -1, 0, 0);
        addRow(opRead, timerByte, 4'hF, 0, 32'h12BB_56DD, 1, -1, 0, 0);
        addRow(opWrite, timerByte + 4, 4'hF, 32'h0000_0000, 0, 1, -1, 0, 0);
        addRow(opWrite, timerByte + 4, 4'h8, 32'h7F00_0000, 0, 1, -1, 0, 0);
        addRow(opRead, timerByte + 4, 4'hF, 0, 32'h7F00_0000, 1, -1, 0, 0);
        addRow(opWrite, timerByte + 8, 4'hF, 32'hCAFE_F00D, 0, 1, -1, 0, 0);
        addRow(opWrite, timerByte + 8, 4'h2, 32'h0000_1100, 0, 1, -1, 0, 0);
        addRow(opRead, timerByte + 8, 4'hF, 0, 32'hCAFE_110D, 1, -1, 0, 0);
        addRow(opWrite, timerByte + 12, 4'hF, 32'h0000_0001, 0, 1, -1, 0, 0);
        // Top bit set in mtimecmp, low only with an unsigned compare.
        addRow(opWrite, timerByte + 12, 4'hC, 32'h8000_0000, 0, 0, -1, 0, 0);
        addRow(opRead, timerByte + 12, 4'hF, 0, 32'h8000_0001, 0, -1, 0, 0);
        addRow(opWrite, timerByte + 4, 4'hF, 32'h8000_0001, 0, 0, -1, 0, 0);
        addRow(opWrite, timerByte, 4'hF, 32'hCAFE_110D, 0, 1, -1, 0, 0);
        addRow(opRead, timerByte, 4'hF, 0, 32'hCAFE_110D, 1, -1, 0, 0);
        addRow(opWrite, timerByte + 8, 4'hF, 32'hFFFF_FFFF, 0, 0, -1, 0, 0);
        // SPI loopback at all three widths.
        addRow(opWrite, spiByte, 4'h1, spiData[0], 0, 0, -1, 0, 0);
        addRow(opRead, spiByte, 4'hF, 0, spiData[0] & 32'h0000_00FF, 0, 8, 0, 0);
        addRow(opRead, spiByte + 4, 4'hF, 0, 0, 0, -1, 0, 0);
        addRow(opWrite, spiByte, 4'h3, spiData[1], 0, 0, -1, 0, 0);
        addRow(opRead, spiByte, 4'hF, 0, spiData[1] & 32'h0000_FFFF, 0, 16, 0, 0);
        addRow(opWrite, spiByte, 4'hF, spiData[2], 0, 0, -1, 0, 0);
        addRow(opRead, spiByte, 4'hF, 0, spiData[2], 0, 32, 0, 0);
        addRow(opWrite, spiByte, 4'h3, spiData[3], 0, 0, -1, 0, 0);
        addRow(opRead, spiByte + 4, 4'hF, 0, 1, 0, 32, 0, 0); // Busy, status not held.
        addRow(opWrite, spiByte, 4'h1, spiData[4], 0, 0, 16, 0, 0); // Held until done.
        addRow(opRead, spiByte, 4'hF, 0, spiData[4] & 32'h0000_00FF, 0, 8, 0, 0);
        addRow(opRead, spiByte + 4, 4'hF, 0, 0, 0, -1, 0, 0);
        // System controller commands.
        addRow(opWrite, sysByte, 4'h1, 32'h0000_0077, 0, 0, -1, 1, 0);
        addRow(opWrite, sysByte, 4'h1, 32'h0000_0055, 0, 0, -1, 0, 1);
        addRow(opWrite, sysByte, 4'h1, 32'h0000_0012, 0, 0, -1, 0, 0);
        addRow(opWrite, sysByte, 4'hE, 32'h7777_7777, 0, 0, -1, 0, 0);
        addRow(opRead, sysByte, 4'hF, 0, 0, 0, -1, 0, 0);
        // Unmapped window.
        addRow(opRead, holeByte, 4'hF, 0, 0, 0, -1, 0, 0);
        addRow(opWrite, holeByte, 4'hF, 32'hDEAD_BEEF, 0, 0, -1, 0, 0);
        addRow(opRead, holeByte, 4'hF, 0, 0, 0, -1, 0, 0);
        addRow(opRead, timerByte + 8, 4'hF, 0, 32'hFFFF_FFFF, 0, -1, 0, 0);
        addRow(opRead, timerByte + 12, 4'hF, 0, 32'h8000_0001, 0, -1, 0, 0);
        cycleLimit = 100 * rowCount;
    endtask

    task automatic busAccess(input bit op, input logic [31:0] adr, input logic [3:0] sel,
                             input logic [31:0] data, output logic [31:0] rd,
                             output int edgesAtAck);
        @(posedge clk);
        #driveDelay;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = op;
        wbSel = sel;
        wbAdr = adr[31:2];
        wbDatW = data;
        @(negedge clk);
        while (wbAck !== 1'b1) @(negedge clk);
        rd = wbDatR;
        edgesAtAck = windowEdges;
        @(posedge clk);
        #driveDelay;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        @(negedge clk);
        assert (wbAck === 1'b0) else begin
            errors++;
            $display("MISMATCH at %0t: acknowledge high for more than one cycle", $time);
        end
    endtask

    task automatic applyRow(input int i);
        logic [31:0] rd;
        int edgesAtAck;
        int rebootBefore;
        int powerOffBefore;
        rebootBefore = rebootCnt;
        powerOffBefore = powerOffCnt;
        busAccess(tblOp[i], tblAdr[i], tblSel[i], tblData[i], rd, edgesAtAck);
        if (tblOp[i] == opRead) begin
            assert (rd === tblExpRd[i]) else begin
                errors++;
                $display("MISMATCH at %0t: row %0d read %h, expected %h",
                         $time, i, rd, tblExpRd[i]);
            end
        end
        if (tblExpIrq[i] >= 0) begin
            assert ((timerIrq === 1'b1) == (tblExpIrq[i] == 1)) else begin
                errors++;
                $display("MISMATCH at %0t: row %0d timerIrq %b, expected %0d",
                         $time, i, timerIrq, tblExpIrq[i]);
            end
        end
        if (tblExpEdges[i] >= 0) begin
            assert (edgesAtAck == tblExpEdges[i]) else begin
                errors++;
                $display("MISMATCH at %0t: row %0d saw %0d SPI edges, expected %0d",
                         $time, i, edgesAtAck, tblExpEdges[i]);
            end
        end
        assert (rebootCnt - rebootBefore == tblExpReboot[i]) else begin
            errors++;
            $display("MISMATCH at %0t: row %0d reboot pulses %0d, expected %0d",
                     $time, i, rebootCnt - rebootBefore, tblExpReboot[i]);
        end
        assert (powerOffCnt - powerOffBefore == tblExpPowerOff[i]) else begin
            errors++;
            $display("MISMATCH at %0t: row %0d powerOff pulses %0d, expected %0d",
                     $time, i, powerOffCnt - powerOffBefore, tblExpPowerOff[i]);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbSel = 4'h0;
        wbAdr = '0;
        wbDatW = 32'd0;
        buildTable();
        repeat (4) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
        for (int i = 0; i < rowCount; i++) begin
            applyRow(i);
        end
        assert (windowCnt == expWindows) else begin
            errors++;
            $display("MISMATCH at %0t: %0d chip-select windows, expected %0d",
                     $time, windowCnt, expWindows);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/mmioSubsystem.sv
`default_nettype none

`include "mmio_params.svh"

module mmioSubsystem (
    input wire clk,
    input wire rst,
    input wire wbCyc,
    input wire wbStb,
    input wire wbWe,
    input wire [3:0] wbSel,
    input wire [`MMIO_ADR_W-1:0] wbAdr,
    input wire [31:0] wbDatW,
    input wire spiMiso,
    output logic [31:0] wbDatR,
    output logic wbAck,
    output logic timerIrq,
    output logic spiCs,
    output logic spiSck,
    output logic spiMosi,
    output logic reboot,
    output logic powerOff
);

    logic [31:0] timerRdata;
    logic [31:0] spiRdata;
    logic [31:0] sysRdata;
    logic spiBusy;
    logic timerRe;
    logic timerWe;
    logic spiRe;
    logic spiWe;
    logic sysWe;
    logic [1:0] regIdx;
    logic [3:0] wmask;
    logic [31:0] wdata;

    busFrontEnd frontEnd_i (
        .clk(clk),
        .rst(rst),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbSel(wbSel),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .timerRdata(timerRdata),
        .spiRdata(spiRdata),
        .sysRdata(sysRdata),
        .spiBusy(spiBusy),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .timerRe(timerRe),
        .timerWe(timerWe),
        .spiRe(spiRe),
        .spiWe(spiWe),
        .sysWe(sysWe),
        .regIdx(regIdx),
        .wmask(wmask),
        .wdata(wdata)
    );

    machineTimer timer_i (
        .clk(clk),
        .rst(rst),
        .re(timerRe),
        .we(timerWe),
        .regIdx(regIdx),
        .wmask(wmask),
        .wdata(wdata),
        .rdata(timerRdata),
        .timerIrq(timerIrq)
    );

    spiMaster spi_i (
        .clk(clk),
        .rst(rst),
        .re(spiRe),
        .we(spiWe),
        .regIdx(regIdx),
        .wmask(wmask),
        .wdata(wdata),
        .spiMiso(spiMiso),
        .rdata(spiRdata),
        .spiBusy(spiBusy),
        .spiCs(spiCs),
        .spiSck(spiSck),
        .spiMosi(spiMosi)
    );

    sysCon sysCon_i (
        .clk(clk),
        .rst(rst),
        .we(sysWe),
        .wmask(wmask),
        .wdata(wdata),
        .rdata(sysRdata),
        .reboot(reboot),
        .powerOff(powerOff)
    );

endmodule

`default_nettype wire

// File: verilog/sysCon.sv
`default_nettype none

module sysCon (
    input wire clk,
    input wire rst,
    input wire we,
    input wire [3:0] wmask,
    input wire [31:0] wdata,
    output logic [31:0] rdata,
    output logic reboot,
    output logic powerOff
);

    logic cmdWr;

    // Command byte lives in lane 0.
    assign cmdWr = we && wmask[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            reboot <= 1'b0;
            powerOff <= 1'b0;
        end else begin
            reboot <= cmdWr && (wdata[7:0] == periphPkg::cmdReboot);
            powerOff <= cmdWr && (wdata[7:0] == periphPkg::cmdPowerOff);
        end
    end

    // Write-only window.
    always_ff @(posedge clk) begin
        rdata <= 32'd0;
    end

endmodule

`default_nettype wire

// File: verilog/spiMaster.sv
`default_nettype none

module spiMaster (
    input wire clk,
    input wire rst,
    input wire re,
    input wire we,
    input wire [1:0] regIdx,
    input wire [3:0] wmask,
    input wire [31:0] wdata,
    input wire spiMiso,
    output logic [31:0] rdata,
    output logic spiBusy,
    output logic spiCs,
    output logic spiSck,
    output logic spiMosi
);

    periphPkg::spiWidth width;
    logic [31:0] shiftReg;
    logic [31:0] loadData;
    logic [5:0] loadCnt;
    logic [5:0] bitCnt;
    logic dataWr;

    // Width from the byte lanes.
    always_comb begin
        case (wmask)
            4'b0001: width = periphPkg::width8;
            4'b0011: width = periphPkg::width16;
            default: width = periphPkg::width32;
        endcase
    end

    // Left-align the payload so the MSB leaves first.
    always_comb begin
        case (width)
            periphPkg::width8: begin
                loadData = {wdata[7:0], 24'd0};
                loadCnt = 6'd8;
            end
            periphPkg::width16: begin
                loadData = {wdata[15:0], 16'd0};
                loadCnt = 6'd16;
            end
            default: begin
                loadData = wdata;
                loadCnt = 6'd32;
            end
        endcase
    end

    assign dataWr = we && (regIdx == 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            bitCnt <= 6'd0;
            spiCs <= 1'b1;
            spiSck <= 1'b0;
            spiMosi <= 1'b0;
        end else if (dataWr) begin
            bitCnt <= loadCnt;
            spiCs <= 1'b0;
            spiSck <= 1'b0;
            spiMosi <= loadData[31];
        end else if (spiSck) begin
            spiSck <= 1'b0;
            spiMosi <= shiftReg[31];
            if (bitCnt == 6'd0) spiCs <= 1'b1; // Last bit done.
        end else if (bitCnt != 6'd0) begin
            spiSck <= 1'b1;
            bitCnt <= bitCnt - 6'd1;
        end
    end

    // Received bits enter at the bottom and end up right-aligned.
    always_ff @(posedge clk) begin
        if (dataWr) begin
            shiftReg <= loadData;
        end else if (!spiSck && (bitCnt != 6'd0)) begin
            shiftReg <= {shiftReg[30:0], spiMiso};
        end
    end

    assign spiBusy = !spiCs;

    always_ff @(posedge clk) begin
        if (re) begin
            if (regIdx == 2'd0) rdata <= shiftReg;
            else rdata <= {31'd0, spiBusy}; // Status.
        end
    end

endmodule

`default_nettype wire

// File: verilog/machineTimer.sv
`default_nettype none

`include "mmio_params.svh"

module machineTimer (
    input wire clk,
    input wire rst,
    input wire re,
    input wire we,
    input wire [1:0] regIdx,
    input wire [3:0] wmask,
    input wire [31:0] wdata,
    output logic [31:0] rdata,
    output logic timerIrq
);

    localparam int divW = $clog2(`MMIO_TIMER_DIV);
    localparam logic [divW-1:0] divLoad = divW'(`MMIO_TIMER_DIV - 1);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [divW-1:0] divCnt;
    logic mtimeWr;

    // Byte-lane merge of a write into an old word.
    function automatic logic [31:0] mergeWord(input logic [31:0] old,
                                              input logic [31:0] din,
                                              input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) res[8*b +: 8] = din[8*b +: 8];
        end
        return res;
    endfunction

    assign mtimeWr = we && !regIdx[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= 64'd0;
            divCnt <= divLoad;
        end else if (mtimeWr) begin
            // Reload so the written value reads back unchanged.
            divCnt <= divLoad;
            if (regIdx[0]) mtime[63:32] <= mergeWord(mtime[63:32], wdata, wmask);
            else mtime[31:0] <= mergeWord(mtime[31:0], wdata, wmask);
        end else if (divCnt == '0) begin
            divCnt <= divLoad;
            mtime <= mtime + 64'd1;
        end else begin
            divCnt <= divCnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= 64'd0;
        end else if (we && regIdx[1]) begin
            if (regIdx[0]) mtimecmp[63:32] <= mergeWord(mtimecmp[63:32], wdata, wmask);
            else mtimecmp[31:0] <= mergeWord(mtimecmp[31:0], wdata, wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            case (regIdx)
                2'd0: rdata <= mtime[31:0];
                2'd1: rdata <= mtime[63:32];
                2'd2: rdata <= mtimecmp[31:0];
                default: rdata <= mtimecmp[63:32];
            endcase
        end
    end

    // Unsigned compare.
    assign timerIrq = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// File: verilog/busFrontEnd.sv
`default_nettype none

`include "mmio_params.svh"

module busFrontEnd (
    input wire clk,
    input wire rst,
    input wire wbCyc,
    input wire wbStb,
    input wire wbWe,
    input wire [3:0] wbSel,
    input wire [`MMIO_ADR_W-1:0] wbAdr,
    input wire [31:0] wbDatW,
    input wire [31:0] timerRdata,
    input wire [31:0] spiRdata,
    input wire [31:0] sysRdata,
    input wire spiBusy,
    output logic [31:0] wbDatR,
    output logic wbAck,
    output logic timerRe,
    output logic timerWe,
    output logic spiRe,
    output logic spiWe,
    output logic sysWe,
    output logic [1:0] regIdx,
    output logic [3:0] wmask,
    output logic [31:0] wdata
);

    localparam logic [31:0] timerBase = `MMIO_TIMER_BASE;
    localparam logic [31:0] spiBase = `MMIO_SPI_BASE;
    localparam logic [31:0] sysConBase = `MMIO_SYSCON_BASE;

    mmioBusPkg::feState state;
    mmioBusPkg::feState nextState;
    mmioBusPkg::devSel hitDev;
    mmioBusPkg::devSel curDev;
    logic [1:0] hitIdx;
    logic curWe;
    logic spiHold;
    logic issue;

    // Address decode into device and word offset.
    always_comb begin
        hitDev = mmioBusPkg::devNone;
        hitIdx = 2'd0;
        if (wbAdr[`MMIO_ADR_W-1:2] == timerBase[31:4]) begin
            hitDev = mmioBusPkg::devTimer;
            hitIdx = wbAdr[1:0];
        end else if (wbAdr[`MMIO_ADR_W-1:1] == spiBase[31:3]) begin
            hitDev = mmioBusPkg::devSpi;
            hitIdx = {1'b0, wbAdr[0]};
        end else if (wbAdr == sysConBase[31:2]) begin
            hitDev = mmioBusPkg::devSysCon;
        end
    end

    // Only the SPI data register waits for a running transfer.
    assign spiHold = (hitDev == mmioBusPkg::devSpi) && (hitIdx == 2'd0) && spiBusy;

    always_comb begin
        nextState = state;
        case (state)
            mmioBusPkg::stIdle: begin
                if (wbCyc && wbStb) begin
                    nextState = spiHold ? mmioBusPkg::stWait : mmioBusPkg::stIssue;
                end
            end
            mmioBusPkg::stWait: begin
                if (!spiBusy) nextState = mmioBusPkg::stIssue;
            end
            mmioBusPkg::stIssue: nextState = mmioBusPkg::stRespond;
            default: nextState = mmioBusPkg::stIdle; // wbStb ignored for this cycle.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mmioBusPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    // Request is held stable by the master, so sampling in idle is enough.
    always_ff @(posedge clk) begin
        if (state == mmioBusPkg::stIdle) begin
            curDev <= hitDev;
            regIdx <= hitIdx;
            curWe <= wbWe;
        end
    end

    assign issue = (state == mmioBusPkg::stIssue);

    assign timerRe = issue && (curDev == mmioBusPkg::devTimer) && !curWe;
    assign timerWe = issue && (curDev == mmioBusPkg::devTimer) && curWe;
    assign spiRe = issue && (curDev == mmioBusPkg::devSpi) && !curWe;
    assign spiWe = issue && (curDev == mmioBusPkg::devSpi) && curWe;
    assign sysWe = issue && (curDev == mmioBusPkg::devSysCon) && curWe;

    assign wmask = wbSel;
    assign wdata = wbDatW;

    assign wbAck = (state == mmioBusPkg::stRespond);

    // Read data select.
    always_comb begin
        wbDatR = 32'd0;
        if (wbAck) begin
            case (curDev)
                mmioBusPkg::devTimer: wbDatR = timerRdata;
                mmioBusPkg::devSpi: wbDatR = spiRdata;
                mmioBusPkg::devSysCon: wbDatR = sysRdata;
                default: wbDatR = 32'd0; // Unmapped reads as zero.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/periphPkg.sv
`default_nettype none

package periphPkg;

    // SPI transfer width, taken from the byte lanes of a data write.
    typedef enum logic [1:0] {
        width8,
        width16,
        width32
    } spiWidth;

    // Magic command bytes of the system controller.
    typedef enum logic [7:0] {
        cmdReboot = 8'h77,
        cmdPowerOff = 8'h55
    } sysCmd;

endpackage

`default_nettype wire

// File: verilog/mmioBusPkg.sv
`default_nettype none

package mmioBusPkg;

    // Peripheral hit by the current request.
    typedef enum logic [1:0] {
        devNone,
        devTimer,
        devSpi,
        devSysCon
    } devSel;

    // Front-end request sequencing.
    typedef enum logic [1:0] {
        stIdle,
        stWait,    // SPI data access held while a transfer runs.
        stIssue,
        stRespond
    } feState;

endpackage

`default_nettype wire

// File: verilog/mmio_params.svh
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Byte base addresses of the peripheral windows.
// Timer window is 4 words, SPI window 2 words, system controller 1 word.
`define MMIO_TIMER_BASE 32'hFF00_0080
`define MMIO_SPI_BASE 32'hFF00_0000
`define MMIO_SYSCON_BASE 32'hFF00_0010

// Clocks per mtime increment.
`define MMIO_TIMER_DIV 50

// Wishbone word address width.
`define MMIO_ADR_W 30

`endif
